// File: flist.f
hw/fetch_pkg.sv
hw/fetch_pc.sv
hw/fetch_btb.sv
hw/fetch_bram.sv
hw/fetch_stage.sv
hw/fetch_top.sv
test/tb_fetch.sv

// File: run.sh
#!/bin/sh
# Build and run the fetch front end testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_fetch \
  -f flist.f \
  -o tb_fetch

# The log decides the result, not the exit status of the run
./obj_dir/tb_fetch 2>&1 | tee sim.log

if grep -qx "sim passed" sim.log; then
  echo "RESULT: PASS"
  exit 0
else
  echo "RESULT: FAIL (see sim.log)"
  exit 1
fi

// File: test/tb_fetch.sv
`timescale 1ns/1ps

module tb_fetch;

  localparam logic [31:0] reset_pc       = 32'h0000_1000;
  localparam int          btb_entries    = 16;
  localparam int          btb_idx_w      = $clog2(btb_entries);
  localparam logic [31:0] prog_base      = 32'h0000_1000;
  localparam int          prog_words     = 128;
  localparam int          prog_aw        = $clog2(prog_words);
  localparam int          num_records    = 400;
  localparam int          test_cycles    = 2000;
  localparam int          timeout_cycles = test_cycles * 3 / 2;

  logic                  clk;
  logic                  rst_n;
  logic                  id_ready;
  logic                  redirect_valid;
  logic [31:0]           redirect_pc;
  logic [31:0]           upd_pc;
  logic [31:0]           upd_tgt;
  logic                  upd_taken;
  logic                  imem_ren;
  logic [31:0]           imem_raddr;
  logic [31:0]           imem_rdata;
  logic                  id_valid;
  logic [31:0]           id_instr;
  logic [31:0]           id_pc;
  logic [31:0]           id_pc_plus4;
  logic                  id_pred_taken;
  logic [31:0]           id_pred_tgt;
  fetch_pkg::ctrl_kind_e id_ctrl_kind;
  logic [31:0]           id_imm;

  logic [31:0] prog [prog_words];
  logic [31:0] seed;
  int          stall_left;
  int          cycles = 0;
  int          accepted = 0;

  // Instruction memory read port state
  logic        rd_pending = 1'b0;
  logic [31:0] rd_addr = 32'd0;

  // Reference BTB
  logic        m_valid [btb_entries];
  logic [31:0] m_tag [btb_entries];
  logic [31:0] m_tgt [btb_entries];
  logic [1:0]  m_ctr [btb_entries];

  // Checker state
  logic [31:0]           exp_pc = reset_pc;
  logic                  hold_chk = 1'b0;
  logic                  h_valid;
  logic [31:0]           h_instr;
  logic [31:0]           h_pc;
  logic [31:0]           h_pc_plus4;
  logic                  h_pred_taken;
  logic [31:0]           h_pred_tgt;
  fetch_pkg::ctrl_kind_e h_kind;
  logic [31:0]           h_imm;
  logic [31:0]           h_raddr;

  fetch_top #(
    .RESET_PC   (reset_pc),
    .BTB_ENTRIES(btb_entries)
  ) dut0 (
    .clk           (clk),
    .rst_n         (rst_n),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .upd_pc        (upd_pc),
    .upd_tgt       (upd_tgt),
    .upd_taken     (upd_taken),
    .imem_ren      (imem_ren),
    .imem_raddr    (imem_raddr),
    .imem_rdata    (imem_rdata),
    .id_ready      (id_ready),
    .id_valid      (id_valid),
    .id_instr      (id_instr),
    .id_pc         (id_pc),
    .id_pc_plus4   (id_pc_plus4),
    .id_pred_taken (id_pred_taken),
    .id_pred_tgt   (id_pred_tgt),
    .id_ctrl_kind  (id_ctrl_kind),
    .id_imm        (id_imm)
  );

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // Outside the program window the word is derived from the address
  function automatic logic [31:0] mem_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - prog_base;
    if (addr >= prog_base && addr < prog_base + 32'(4 * prog_words)) begin
      return prog[off[prog_aw+1:2]];
    end
    return addr ^ 32'h6b3d_2c91;
  endfunction

  function automatic logic [32:0] btb_lookup(input logic [31:0] pc);
    logic [btb_idx_w-1:0] idx;
    logic [31:0]          tag;
    idx = pc[btb_idx_w+1:2];
    tag = pc >> (btb_idx_w + 2);
    return {m_valid[idx] && (m_tag[idx] == tag) && (m_ctr[idx] >= 2'd2), m_tgt[idx]};
  endfunction

  task automatic btb_update(input logic [31:0] pc, input logic [31:0] tgt, input logic taken);
    logic [btb_idx_w-1:0] idx;
    logic [31:0]          tag;
    idx = pc[btb_idx_w+1:2];
    tag = pc >> (btb_idx_w + 2);
    if (m_valid[idx] && m_tag[idx] == tag) begin
      if (taken && m_ctr[idx] < 2'd3) begin
        m_ctr[idx] = m_ctr[idx] + 2'd1;
      end else if (!taken && m_ctr[idx] > 2'd0) begin
        m_ctr[idx] = m_ctr[idx] - 2'd1;
      end
      if (taken) begin
        m_tgt[idx] = tgt;
      end
    end else if (taken) begin
      m_valid[idx] = 1'b1;
      m_tag[idx]   = tag;
      m_tgt[idx]   = tgt;
      m_ctr[idx]   = 2'd2;
    end
  endtask

  function automatic logic [31:0] expect_next(input logic [31:0] pc, input logic taken,
                                              input logic [31:0] tgt);
    if (taken) begin
      return tgt;
    end
    return pc + 32'd4;
  endfunction

  // Kind in the top two bits, immediate below
  function automatic logic [33:0] predecode_ref(input logic [31:0] w);
    logic [31:0] b_imm;
    logic [31:0] j_imm;
    b_imm = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
    j_imm = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
    case (w[6:0])
      fetch_pkg::opc_branch: return {fetch_pkg::ctrl_branch, b_imm};
      fetch_pkg::opc_jal:    return {fetch_pkg::ctrl_jal, j_imm};
      fetch_pkg::opc_jalr:   return {fetch_pkg::ctrl_jalr, 32'd0};
      default:               return {fetch_pkg::ctrl_none, 32'd0};
    endcase
  endfunction

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("FAIL t=%0t %s got=%08h exp=%08h", $time, name, got, exp);
      $display("sim failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  // Roughly one word in eight is a control transfer
  task automatic fill_program();
    logic [31:0] sel;
    logic [6:0]  opc;
    for (int i = 0; i < prog_words; i++) begin
      seed = xorshift(seed);
      sel  = seed;
      seed = xorshift(seed);
      if (sel[2:0] == 3'd0) begin
        case (sel[4:3])
          2'd0, 2'd1: opc = fetch_pkg::opc_branch;
          2'd2:       opc = fetch_pkg::opc_jal;
          default:    opc = fetch_pkg::opc_jalr;
        endcase
      end else begin
        opc = 7'b001_0011;
      end
      prog[i] = {seed[31:7], opc};
    end
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
  end

  // Synchronous read that returns garbage unless a read was issued on the last edge
  always @(posedge clk) begin
    if (imem_ren) begin
      rd_pending <= 1'b1;
      rd_addr    <= imem_raddr;
    end else begin
      rd_pending <= 1'b0;
    end
  end

  assign imem_rdata = rd_pending ? mem_word(rd_addr) : 32'hdead_beef;

  initial begin
    rst_n          <= 1'b0;
    id_ready       <= 1'b0;
    redirect_valid <= 1'b0;
    redirect_pc    <= 32'd0;
    upd_pc         <= 32'd0;
    upd_tgt        <= 32'd0;
    upd_taken      <= 1'b0;
    seed       = 32'h079b_b0d8;
    stall_left = 0;
    fill_program();
    repeat (16) @(posedge clk);
    rst_n <= 1'b1;
    forever begin
      @(posedge clk);
      seed = xorshift(seed);
      if (stall_left > 0) begin
        id_ready <= 1'b0;
        stall_left = stall_left - 1;
      end else if (seed[7:2] == 6'd0) begin
        // Occasional long stall to exercise the hold buffer
        id_ready <= 1'b0;
        stall_left = 8 + int'(seed[12:9]);
      end else begin
        id_ready <= (seed[1:0] != 2'b00);
      end
      seed = xorshift(seed);
      if (cycles > 40 && seed % 20 == 0) begin
        redirect_valid <= 1'b1;
        redirect_pc    <= prog_base + {25'd0, seed[9:5], 2'b00};
        upd_pc         <= prog_base + {25'd0, seed[14:10], 2'b00};
        upd_tgt        <= prog_base + {23'd0, seed[21:15], 2'b00};
        upd_taken      <= (seed[27:26] != 2'b00);
      end else begin
        redirect_valid <= 1'b0;
      end
    end
  end

  always @(posedge clk) begin : compare_proc
    logic [32:0] lu;
    logic [33:0] pd;
    if (!rst_n) begin
      for (int i = 0; i < btb_entries; i++) begin
        m_valid[i] = 1'b0;
      end
      if (cycles >= 2) begin
        check_value("id_valid", {31'd0, id_valid}, 32'd0);
      end
    end else begin
      // Memory is read whenever the IF/ID register is empty or decode takes it
      check_value("imem_ren", {31'd0, imem_ren}, {31'd0, !id_valid || id_ready});
      if (hold_chk) begin
        check_value("id_valid", {31'd0, id_valid}, {31'd0, h_valid});
        check_value("id_instr", id_instr, h_instr);
        check_value("id_pc", id_pc, h_pc);
        check_value("id_pc_plus4", id_pc_plus4, h_pc_plus4);
        check_value("id_pred_taken", {31'd0, id_pred_taken}, {31'd0, h_pred_taken});
        check_value("id_pred_tgt", id_pred_tgt, h_pred_tgt);
        check_value("id_ctrl_kind", {30'd0, id_ctrl_kind}, {30'd0, h_kind});
        check_value("id_imm", id_imm, h_imm);
        check_value("imem_raddr", imem_raddr, h_raddr);
      end
      if (id_valid && id_ready) begin
        lu = btb_lookup(id_pc);
        pd = predecode_ref(mem_word(id_pc));
        check_value("id_pc", id_pc, exp_pc);
        check_value("id_instr", id_instr, mem_word(id_pc));
        check_value("id_pc_plus4", id_pc_plus4, id_pc + 32'd4);
        check_value("id_pred_taken", {31'd0, id_pred_taken}, {31'd0, lu[32]});
        if (lu[32]) begin
          check_value("id_pred_tgt", id_pred_tgt, lu[31:0]);
        end
        check_value("id_ctrl_kind", {30'd0, id_ctrl_kind}, {30'd0, pd[33:32]});
        check_value("id_imm", id_imm, pd[31:0]);
        exp_pc = expect_next(id_pc, lu[32], lu[31:0]);
        accepted = accepted + 1;
      end
      // Redirect also trains the BTB on the same edge
      if (redirect_valid) begin
        btb_update(upd_pc, upd_tgt, upd_taken);
        exp_pc = redirect_pc;
      end
      hold_chk     = id_valid && !id_ready && !redirect_valid;
      h_valid      = id_valid;
      h_instr      = id_instr;
      h_pc         = id_pc;
      h_pc_plus4   = id_pc_plus4;
      h_pred_taken = id_pred_taken;
      h_pred_tgt   = id_pred_tgt;
      h_kind       = id_ctrl_kind;
      h_imm        = id_imm;
      h_raddr      = imem_raddr;
    end
  end

  initial begin
    wait (accepted >= num_records || cycles >= timeout_cycles);
    if (accepted >= num_records) begin
      $display("sim passed");
      $finish;
    end else begin
      $display("Timeout after %0d cycles, only %0d records accepted", cycles, accepted);
      $display("sim failed");
      $fatal(1, "run did not finish in time");
    end
  end

endmodule

// File: hw/fetch_top.sv
`timescale 1ns/1ps

module fetch_top #(
  parameter logic [fetch_pkg::xlen-1:0] RESET_PC    = 32'h0000_1000,
  parameter int                         BTB_ENTRIES = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // Redirect and BTB update from execute
  input  logic                        redirect_valid,
  input  logic [fetch_pkg::xlen-1:0]  redirect_pc,
  input  logic [fetch_pkg::xlen-1:0]  upd_pc,
  input  logic [fetch_pkg::xlen-1:0]  upd_tgt,
  input  logic                        upd_taken,

  // Instruction memory
  output logic                        imem_ren,
  output logic [fetch_pkg::xlen-1:0]  imem_raddr,
  input  logic [31:0]                 imem_rdata,

  // Decode side
  input  logic                        id_ready,
  output logic                        id_valid,
  output logic [31:0]                 id_instr,
  output logic [fetch_pkg::xlen-1:0]  id_pc,
  output logic [fetch_pkg::xlen-1:0]  id_pc_plus4,
  output logic                        id_pred_taken,
  output logic [fetch_pkg::xlen-1:0]  id_pred_tgt,
  output fetch_pkg::ctrl_kind_e       id_ctrl_kind,
  output logic [31:0]                 id_imm
);

  logic                       advance;
  logic [fetch_pkg::xlen-1:0] pc_f;
  logic                       lookup_taken;
  logic [fetch_pkg::xlen-1:0] lookup_tgt;
  logic                       pred_taken_r;
  logic [fetch_pkg::xlen-1:0] pred_tgt_r;
  logic                       valid_r;
  logic [fetch_pkg::xlen-1:0] pc_r;
  logic [31:0]                instr_r;

  fetch_pc #(
    .RESET_PC(RESET_PC)
  ) u_pc (
    .clk           (clk),
    .rst_n         (rst_n),
    .advance       (advance),
    .redirect_valid(redirect_valid),
    .redirect_pc   (redirect_pc),
    .lookup_taken  (lookup_taken),
    .lookup_tgt    (lookup_tgt),
    .pc_f          (pc_f)
  );

  // Updates only ever come with a redirect
  fetch_btb #(
    .BTB_ENTRIES(BTB_ENTRIES)
  ) u_btb (
    .clk         (clk),
    .rst_n       (rst_n),
    .advance     (advance),
    .flush       (redirect_valid),
    .pc_f        (pc_f),
    .upd_valid   (redirect_valid),
    .upd_pc      (upd_pc),
    .upd_tgt     (upd_tgt),
    .upd_taken   (upd_taken),
    .lookup_taken(lookup_taken),
    .lookup_tgt  (lookup_tgt),
    .pred_taken_r(pred_taken_r),
    .pred_tgt_r  (pred_tgt_r)
  );

  fetch_bram u_bram (
    .clk       (clk),
    .rst_n     (rst_n),
    .advance   (advance),
    .flush     (redirect_valid),
    .pc_f      (pc_f),
    .imem_ren  (imem_ren),
    .imem_raddr(imem_raddr),
    .imem_rdata(imem_rdata),
    .valid_r   (valid_r),
    .pc_r      (pc_r),
    .instr_r   (instr_r)
  );

  fetch_stage u_stage (
    .clk          (clk),
    .rst_n        (rst_n),
    .flush        (redirect_valid),
    .id_ready     (id_ready),
    .valid_r      (valid_r),
    .pc_r         (pc_r),
    .instr_r      (instr_r),
    .pred_taken_r (pred_taken_r),
    .pred_tgt_r   (pred_tgt_r),
    .advance      (advance),
    .id_valid     (id_valid),
    .id_instr     (id_instr),
    .id_pc        (id_pc),
    .id_pc_plus4  (id_pc_plus4),
    .id_pred_taken(id_pred_taken),
    .id_pred_tgt  (id_pred_tgt),
    .id_ctrl_kind (id_ctrl_kind),
    .id_imm       (id_imm)
  );

endmodule

// File: hw/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        flush,
  input  logic                        id_ready,

  // From the BRAM path
  input  logic                        valid_r,
  input  logic [fetch_pkg::xlen-1:0]  pc_r,
  input  logic [31:0]                 instr_r,

  // From the BTB prediction register
  input  logic                        pred_taken_r,
  input  logic [fetch_pkg::xlen-1:0]  pred_tgt_r,

  output logic                        advance,

  // Record to decode
  output logic                        id_valid,
  output logic [31:0]                 id_instr,
  output logic [fetch_pkg::xlen-1:0]  id_pc,
  output logic [fetch_pkg::xlen-1:0]  id_pc_plus4,
  output logic                        id_pred_taken,
  output logic [fetch_pkg::xlen-1:0]  id_pred_tgt,
  output fetch_pkg::ctrl_kind_e       id_ctrl_kind,
  output logic [31:0]                 id_imm
);

  fetch_pkg::instr_u     word;
  fetch_pkg::ctrl_kind_e kind;
  logic [31:0]           imm;
  logic [31:0]           b_imm;
  logic [31:0]           j_imm;

  // Register can take a new record when empty or when decode takes the old one
  assign advance = !id_valid || id_ready;

  assign word = instr_r;

  assign b_imm = {{20{word.b_view.imm_12}}, word.b_view.imm_11,
                  word.b_view.imm_10_5, word.b_view.imm_4_1, 1'b0};
  assign j_imm = {{12{word.j_view.imm_20}}, word.j_view.imm_19_12,
                  word.j_view.imm_11, word.j_view.imm_10_1, 1'b0};

  // Opcode sits in the same bits in both views
  always_comb begin
    case (word.b_view.opcode)
      fetch_pkg::opc_branch: begin
        kind = fetch_pkg::ctrl_branch;
        imm  = b_imm;
      end
      fetch_pkg::opc_jal: begin
        kind = fetch_pkg::ctrl_jal;
        imm  = j_imm;
      end
      fetch_pkg::opc_jalr: begin
        // Target depends on rs1, nothing static to offer
        kind = fetch_pkg::ctrl_jalr;
        imm  = '0;
      end
      default: begin
        kind = fetch_pkg::ctrl_none;
        imm  = '0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      id_valid <= 1'b0;
    end else if (advance) begin
      id_valid <= valid_r;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      id_instr      <= instr_r;
      id_pc         <= pc_r;
      id_pc_plus4   <= pc_r + fetch_pkg::xlen'(4);
      id_pred_taken <= pred_taken_r;
      id_pred_tgt   <= pred_tgt_r;
      id_ctrl_kind  <= kind;
      id_imm        <= imm;
    end
  end

endmodule

// File: hw/fetch_bram.sv
`timescale 1ns/1ps

module fetch_bram (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        advance,
  input  logic                        flush,
  input  logic [fetch_pkg::xlen-1:0]  pc_f,

  // Synchronous instruction memory, data one cycle after ren
  output logic                        imem_ren,
  output logic [fetch_pkg::xlen-1:0]  imem_raddr,
  input  logic [31:0]                 imem_rdata,

  // Word returned for the PC that was in flight
  output logic                        valid_r,
  output logic [fetch_pkg::xlen-1:0]  pc_r,
  output logic [31:0]                 instr_r
);

  logic [31:0] hold_buf;
  logic        held;

  // Read only when the pipe moves, so the BRAM output is never overwritten
  // by a fetch nobody will take
  assign imem_ren   = advance;
  assign imem_raddr = pc_f;

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      valid_r <= 1'b0;
    end else if (advance) begin
      valid_r <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (advance) begin
      pc_r <= pc_f;
    end
  end

  // First stalled cycle still sees the good word on imem_rdata;
  // after that the memory output is not defined, so keep a copy
  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      held <= 1'b0;
    end else if (advance) begin
      held <= 1'b0;
    end else if (!held) begin
      held <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (!advance && !held) begin
      hold_buf <= imem_rdata;
    end
  end

  assign instr_r = held ? hold_buf : imem_rdata;

endmodule

// File: hw/fetch_btb.sv
`timescale 1ns/1ps

module fetch_btb #(
  parameter int BTB_ENTRIES = 16
) (
  input  logic                        clk,
  input  logic                        rst_n,

  input  logic                        advance,
  input  logic                        flush,
  input  logic [fetch_pkg::xlen-1:0]  pc_f,

  // Resolved control transfer from execute
  input  logic                        upd_valid,
  input  logic [fetch_pkg::xlen-1:0]  upd_pc,
  input  logic [fetch_pkg::xlen-1:0]  upd_tgt,
  input  logic                        upd_taken,

  // Lookup for the PC being fetched now
  output logic                        lookup_taken,
  output logic [fetch_pkg::xlen-1:0]  lookup_tgt,

  // Same prediction, one cycle later, lined up with the BRAM word
  output logic                        pred_taken_r,
  output logic [fetch_pkg::xlen-1:0]  pred_tgt_r
);

  localparam int idx_w = $clog2(BTB_ENTRIES);
  localparam int tag_w = fetch_pkg::xlen - idx_w - 2;

  logic [BTB_ENTRIES-1:0]      valid_q;
  logic [tag_w-1:0]            tag_q [BTB_ENTRIES];
  logic [fetch_pkg::xlen-1:0]  tgt_q [BTB_ENTRIES];
  logic [1:0]                  ctr_q [BTB_ENTRIES];

  logic [idx_w-1:0]            lu_idx;
  logic [tag_w-1:0]            lu_tag;
  logic [idx_w-1:0]            up_idx;
  logic [tag_w-1:0]            up_tag;
  logic                        up_hit;

  // Word index sits just above the byte offset, tag takes the rest
  assign lu_idx = pc_f[idx_w+1:2];
  assign lu_tag = pc_f[fetch_pkg::xlen-1:idx_w+2];
  assign up_idx = upd_pc[idx_w+1:2];
  assign up_tag = upd_pc[fetch_pkg::xlen-1:idx_w+2];

  // Predict taken only for weakly or strongly taken entries
  assign lookup_taken = valid_q[lu_idx] && (tag_q[lu_idx] == lu_tag) && ctr_q[lu_idx][1];
  assign lookup_tgt   = tgt_q[lu_idx];

  assign up_hit = valid_q[up_idx] && (tag_q[up_idx] == up_tag);

  // Entry valid bits, set on allocation
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (upd_valid && !up_hit && upd_taken) begin
      valid_q[up_idx] <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (upd_valid) begin
      if (up_hit) begin
        // Saturating 2-bit counter
        if (upd_taken && ctr_q[up_idx] != 2'd3) begin
          ctr_q[up_idx] <= ctr_q[up_idx] + 2'd1;
        end else if (!upd_taken && ctr_q[up_idx] != 2'd0) begin
          ctr_q[up_idx] <= ctr_q[up_idx] - 2'd1;
        end
        if (upd_taken) begin
          tgt_q[up_idx] <= upd_tgt;
        end
      end else if (upd_taken) begin
        // Allocate as weakly taken
        tag_q[up_idx] <= up_tag;
        tgt_q[up_idx] <= upd_tgt;
        ctr_q[up_idx] <= 2'd2;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n || flush) begin
      pred_taken_r <= 1'b0;
      pred_tgt_r   <= '0;
    end else if (advance) begin
      pred_taken_r <= lookup_taken;
      pred_tgt_r   <= lookup_tgt;
    end
  end

endmodule

// File: hw/fetch_pc.sv
`timescale 1ns/1ps

module fetch_pc #(
  parameter logic [fetch_pkg::xlen-1:0] RESET_PC = 32'h0000_1000
) (
  input  logic                        clk,
  input  logic                        rst_n,

  // Pipeline control
  input  logic                        advance,
  input  logic                        redirect_valid,
  input  logic [fetch_pkg::xlen-1:0]  redirect_pc,

  // Combinational BTB result for the current pc_f
  input  logic                        lookup_taken,
  input  logic [fetch_pkg::xlen-1:0]  lookup_tgt,

  output logic [fetch_pkg::xlen-1:0]  pc_f
);

  logic [fetch_pkg::xlen-1:0] pc_seq;
  logic [fetch_pkg::xlen-1:0] pc_next;
  logic                       pc_load;

  assign pc_seq = pc_f + fetch_pkg::xlen'(4);

  // Redirect from execute wins over the BTB, which wins over sequential fetch
  always_comb begin
    if (redirect_valid) begin
      pc_next = redirect_pc;
    end else if (lookup_taken) begin
      pc_next = lookup_tgt;
    end else begin
      pc_next = pc_seq;
    end
  end

  // A redirect reloads even while the pipe is stalled
  assign pc_load = advance || redirect_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc_f <= RESET_PC;
    end else if (pc_load) begin
      pc_f <= pc_next;
    end
  end

endmodule

// File: hw/fetch_pkg.sv
package fetch_pkg;

  // Address and data width of the fetch path
  localparam int xlen = 32;

  // Control-transfer kind found by predecode
  typedef enum logic [1:0] {
    ctrl_none   = 2'd0,
    ctrl_branch = 2'd1,
    ctrl_jal    = 2'd2,
    ctrl_jalr   = 2'd3
  } ctrl_kind_e;

  // RV32 major opcodes of the control-transfer instructions
  localparam logic [6:0] opc_branch = 7'b110_0011;
  localparam logic [6:0] opc_jal    = 7'b110_1111;
  localparam logic [6:0] opc_jalr   = 7'b110_0111;

  // One instruction word, seen either as B-type or as J-type
  typedef union packed {
    struct packed {
      logic       imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic       imm_11;
      logic [6:0] opcode;
    } b_view;
    struct packed {
      logic       imm_20;
      logic [9:0] imm_10_1;
      logic       imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j_view;
  } instr_u;

endpackage
